/* filelist.f */
source/sys_pkg.sv
source/mem_bus_if.sv
source/sys_xbar.sv
source/l2_sram.sv
source/bootrom.sv
source/ctrl_regs.sv
source/mem_system.sv
dv/tb_mem_system.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  - source/sys_pkg.sv
  - source/mem_bus_if.sv
  - source/sys_xbar.sv
  - source/l2_sram.sv
  - source/bootrom.sv
  - source/ctrl_regs.sv
  - source/mem_system.sv
  - target: test
    files:
      - dv/tb_mem_system.sv

/* dv/tb_mem_system.sv */
////////////////////////////////////////////////////////////
// Testbench for the memory system. Applies a stimulus table
// on both ports and models the external target
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mem_system;
  import sys_pkg::*;

  localparam int    ClkPeriod   = 100;
  localparam int    SampleDelay = 40;  // 10 ns before the rising edge
  localparam int    ResetCycles = 16;
  localparam int    NumRounds   = 4;
  localparam data_t ExtXorKey   = 32'h5A5A_5A5A;

  typedef struct {
    string               name;
    int                  port;  // 0 cluster, 1 host
    logic                we;
    addr_t               addr;
    data_t               wdata;
    strb_t               be;
    data_t               exp_rdata;
    bit                  chk_rdata;
    logic [NumCores-1:0] exp_wake;
    logic                exp_eoc;
    bit                  is_ext;
  } row_t;

  logic                clk_i;
  logic                rst_i;
  logic                req_s    [2];
  logic                we_s     [2];
  addr_t               addr_s   [2];
  data_t               wdata_s  [2];
  strb_t               be_s     [2];
  logic                gnt_s    [2];
  logic                rvalid_s [2];
  data_t               rdata_s  [2];
  logic                ext_req_o;
  logic                ext_we_o;
  addr_t               ext_addr_o;
  data_t               ext_wdata_o;
  strb_t               ext_be_o;
  logic                ext_gnt_i;
  logic                ext_rvalid_i;
  data_t               ext_rdata_i;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o;

  row_t  rows [$];
  data_t l2_ref [L2NumWords];  // Expected L2 contents
  logic  eoc_ref;
  int    cyc = 0;
  int    limit_cycles = 0;
  int    num_checks = 0;
  int    data_errs = 0;
  int    bit_errs = 0;
  int    wake_errs = 0;
  int    be_errs = 0;
  int    gnt_cnt [2] = '{0, 0};
  int    rv_cnt [2] = '{0, 0};

  // External target model state
  addr_t rsp_addr_q [$];
  int    rsp_due_q [$];
  int    stall = 2;
  int    last_due = 0;
  addr_t ext_last_addr;
  data_t ext_last_wdata;
  logic  ext_last_we;
  strb_t ext_last_be;

  mem_system u_dut (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .clu_req_i    (req_s[0]   ),
    .clu_we_i     (we_s[0]    ),
    .clu_addr_i   (addr_s[0]  ),
    .clu_wdata_i  (wdata_s[0] ),
    .clu_be_i     (be_s[0]    ),
    .clu_gnt_o    (gnt_s[0]   ),
    .clu_rvalid_o (rvalid_s[0]),
    .clu_rdata_o  (rdata_s[0] ),
    .host_req_i   (req_s[1]   ),
    .host_we_i    (we_s[1]    ),
    .host_addr_i  (addr_s[1]  ),
    .host_wdata_i (wdata_s[1] ),
    .host_be_i    (be_s[1]    ),
    .host_gnt_o   (gnt_s[1]   ),
    .host_rvalid_o(rvalid_s[1]),
    .host_rdata_o (rdata_s[1] ),
    .ext_req_o    (ext_req_o  ),
    .ext_we_o     (ext_we_o   ),
    .ext_addr_o   (ext_addr_o ),
    .ext_wdata_o  (ext_wdata_o),
    .ext_be_o     (ext_be_o   ),
    .ext_gnt_i    (ext_gnt_i  ),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .wake_up_o    (wake_up_o  ),
    .eoc_valid_o  (eoc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_data(string name, data_t exp, data_t act);
    num_checks++;
    if (act !== exp) begin
      data_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    num_checks++;
    if (act !== exp) begin
      bit_errs++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_wake(string name, logic [NumCores-1:0] exp, logic [NumCores-1:0] act);
    num_checks++;
    if (act !== exp) begin
      wake_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_strb(string name, strb_t exp, strb_t act);
    num_checks++;
    if (act !== exp) begin
      be_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic int total_errors();
    return data_errs + bit_errs + wake_errs + be_errs;
  endfunction

  task automatic report_counts();
    $display("Checks %0d, errors %0d (data %0d, bit %0d, wake %0d, be %0d)",
             num_checks, total_errors(), data_errs, bit_errs, wake_errs, be_errs);
  endtask

  task automatic check_reset_outputs(string tag);
    for (int p = 0; p < 2; p++) begin
      check_bit({tag, " gnt"}, 1'b0, gnt_s[p]);
      check_bit({tag, " rvalid"}, 1'b0, rvalid_s[p]);
    end
    check_bit({tag, " ext_req"}, 1'b0, ext_req_o);
    check_wake({tag, " wake_up"}, '0, wake_up_o);
    check_bit({tag, " eoc_valid"}, 1'b0, eoc_valid_o);
  endtask

  // One transaction: request until granted, then wait for its response
  task automatic run_txn(input int p, input logic we, input addr_t addr, input data_t wdata,
                         input strb_t be, output data_t rdata, output int gnt_cyc);
    @(negedge clk_i);
    req_s[p]   = 1'b1;
    we_s[p]    = we;
    addr_s[p]  = addr;
    wdata_s[p] = wdata;
    be_s[p]    = be;
    #SampleDelay;
    while (!gnt_s[p]) begin
      @(negedge clk_i);
      #SampleDelay;
    end
    gnt_cyc = cyc;
    @(negedge clk_i);
    req_s[p] = 1'b0;
    #SampleDelay;
    while (!rvalid_s[p]) begin
      @(negedge clk_i);
      #SampleDelay;
    end
    rdata = rdata_s[p];
  endtask

  task automatic add_row(string name, int port, logic we, addr_t addr, data_t wdata, strb_t be,
                         data_t exp_rdata, bit chk_rdata, logic [NumCores-1:0] exp_wake,
                         bit is_ext);
    rows.push_back(row_t'{name, port, we, addr, wdata, be, exp_rdata, chk_rdata, exp_wake,
                          eoc_ref, is_ext});
  endtask

  task automatic l2_write_row(string name, int port, int idx, strb_t be);
    data_t wd;
    wd = $urandom;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) l2_ref[idx][8*b +: 8] = wd[8*b +: 8];  // Merge under byte enables
    end
    add_row(name, port, 1'b1, L2Base + addr_t'(idx * 4), wd, be, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic build_table();
    eoc_u  eoc_w;
    data_t wd;
    addr_t a;
    eoc_ref = 1'b0;
    for (int i = 1; i <= 6; i++) l2_write_row($sformatf("l2 write %0d", i), 0, i * 37, 4'hF);
    l2_write_row("l2 partial 0011", 1, 37, 4'b0011);
    l2_write_row("l2 partial 1000", 1, 111, 4'b1000);
    l2_write_row("l2 partial 0101", 1, 185, 4'b0101);
    for (int i = 1; i <= 6; i++) begin
      add_row($sformatf("l2 read %0d", i), i % 2, 1'b0, L2Base + addr_t'(i * 148), '0, 4'hF,
              l2_ref[i * 37], 1'b1, '0, 1'b0);
    end
    // Boot ROM, image then zero past the end
    add_row("rom word 0", 0, 1'b0, RomBase, '0, 4'hF, BootImage[0], 1'b1, '0, 1'b0);
    add_row("rom word 7", 0, 1'b0, RomBase + 28, '0, 4'hF, BootImage[7], 1'b1, '0, 1'b0);
    add_row("rom word 15", 1, 1'b0, RomBase + 60, '0, 4'hF, BootImage[15], 1'b1, '0, 1'b0);
    add_row("rom word 16", 1, 1'b0, RomBase + 64, '0, 4'hF, '0, 1'b1, '0, 1'b0);
    add_row("rom word 100", 0, 1'b0, RomBase + 400, '0, 4'hF, '0, 1'b1, '0, 1'b0);
    add_row("rom write", 1, 1'b1, RomBase + 12, $urandom, 4'hF, '0, 1'b0, '0, 1'b0);
    add_row("rom after write", 0, 1'b0, RomBase + 12, '0, 4'hF, BootImage[3], 1'b1, '0, 1'b0);
    // Control registers
    add_row("ctrl tcdm start", 1, 1'b0, CtrlBase + 8, '0, 4'hF, TcdmBase, 1'b1, '0, 1'b0);
    add_row("ctrl tcdm end", 0, 1'b0, CtrlBase + 12, '0, 4'hF, TcdmBase + TcdmSize - 1, 1'b1,
            '0, 1'b0);
    add_row("ctrl num cores", 1, 1'b0, CtrlBase + 16, '0, 4'hF, data_t'(NumCores), 1'b1, '0,
            1'b0);
    add_row("ctrl unmapped", 0, 1'b0, CtrlBase + 32, '0, 4'hF, '0, 1'b1, '0, 1'b0);
    wd = $urandom | 32'h1;  // At least one core woken
    add_row("ctrl wake write", 0, 1'b1, CtrlBase + 4, wd, 4'hF, '0, 1'b0, wd[NumCores-1:0], 1'b0);
    add_row("ctrl wake read", 1, 1'b0, CtrlBase + 4, '0, 4'hF, '0, 1'b1, '0, 1'b0);
    eoc_w.fields.code = 31'($urandom);
    eoc_w.fields.done = 1'b1;
    eoc_ref = 1'b1;
    add_row("ctrl eoc set", 0, 1'b1, CtrlBase, eoc_w.raw, 4'hF, '0, 1'b0, '0, 1'b0);
    add_row("ctrl eoc read", 1, 1'b0, CtrlBase, '0, 4'hF, eoc_w.raw, 1'b1, '0, 1'b0);
    eoc_w.fields.code = 31'($urandom);
    eoc_w.fields.done = 1'b0;
    eoc_ref = 1'b0;
    add_row("ctrl eoc clear", 1, 1'b1, CtrlBase, eoc_w.raw, 4'hF, '0, 1'b0, '0, 1'b0);
    add_row("ctrl eoc reread", 0, 1'b0, CtrlBase, '0, 4'hF, eoc_w.raw, 1'b1, '0, 1'b0);
    // External port, edges of the map and random addresses
    add_row("ext low", 0, 1'b0, 32'h1000_0000, '0, 4'hF, 32'h1000_0000 ^ ExtXorKey, 1'b1, '0,
            1'b1);
    add_row("ext past ctrl", 1, 1'b0, CtrlEnd + 1, '0, 4'hF, (CtrlEnd + 1) ^ ExtXorKey, 1'b1,
            '0, 1'b1);
    add_row("ext past l2", 0, 1'b0, L2End + 1, '0, 4'hF, (L2End + 1) ^ ExtXorKey, 1'b1, '0, 1'b1);
    add_row("ext write", 1, 1'b1, RomEnd + 1, $urandom, 4'b0110, '0, 1'b0, '0, 1'b1);
    for (int k = 0; k < 6; k++) begin
      a = 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);
      add_row($sformatf("ext random %0d", k), k % 2, 1'b0, a, '0, 4'hF, a ^ ExtXorKey, 1'b1,
              '0, 1'b1);
    end
  endtask

  // External target: random grant stall, in-order responses 1 to 4 cycles later
  initial begin
    int lat;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    forever begin
      @(negedge clk_i);
      ext_gnt_i    = (stall == 0);
      ext_rvalid_i = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = rsp_addr_q.pop_front() ^ ExtXorKey;
        void'(rsp_due_q.pop_front());
      end
      #SampleDelay;
      if (!rst_i && ext_req_o) begin
        if (ext_gnt_i) begin
          lat      = 1 + int'($urandom % 4);
          last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
          rsp_addr_q.push_back(ext_addr_o);
          rsp_due_q.push_back(last_due);
          ext_last_addr  = ext_addr_o;
          ext_last_wdata = ext_wdata_o;
          ext_last_we    = ext_we_o;
          ext_last_be    = ext_be_o;
          stall = $urandom % 4;
        end else begin
          stall--;
        end
      end
    end
  end

  // Grant and response counters per port
  initial begin
    forever begin
      @(negedge clk_i);
      #SampleDelay;
      if (!rst_i) begin
        for (int p = 0; p < 2; p++) begin
          if (req_s[p] && gnt_s[p]) gnt_cnt[p]++;
          if (rvalid_s[p]) rv_cnt[p]++;
        end
      end
    end
  end

  initial begin
    do begin
      @(posedge clk_i);
      cyc++;
    end while (cyc < limit_cycles);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    report_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    data_t rd0;
    data_t rd1;
    data_t wd0;
    data_t wd1;
    int    gc0;
    int    gc1;
    logic  win;
    logic  prev_win;
    void'($urandom(60));
    rst_i = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req_s[p]   = 1'b0;
      we_s[p]    = 1'b0;
      addr_s[p]  = '0;
      wdata_s[p] = '0;
      be_s[p]    = '0;
    end
    build_table();
    limit_cycles = 40 * (rows.size() + NumRounds + 1) + 200;

    for (int n = 0; n < ResetCycles; n++) begin
      @(negedge clk_i);
      #SampleDelay;
      if (n > 0) check_reset_outputs("in reset");  // Registers clear on the first rising edge
    end
    @(negedge clk_i);
    rst_i = 1'b0;
    #SampleDelay;
    check_reset_outputs("after reset");

    foreach (rows[k]) begin
      run_txn(rows[k].port, rows[k].we, rows[k].addr, rows[k].wdata, rows[k].be, rd0, gc0);
      if (rows[k].chk_rdata) check_data(rows[k].name, rows[k].exp_rdata, rd0);
      check_wake({rows[k].name, " wake_up"}, rows[k].exp_wake, wake_up_o);
      check_bit({rows[k].name, " eoc_valid"}, rows[k].exp_eoc, eoc_valid_o);
      if (rows[k].is_ext) begin
        check_data({rows[k].name, " ext addr"}, rows[k].addr, ext_last_addr);
        check_bit({rows[k].name, " ext we"}, rows[k].we, ext_last_we);
        check_strb({rows[k].name, " ext be"}, rows[k].be, ext_last_be);
        if (rows[k].we) check_data({rows[k].name, " ext wdata"}, rows[k].wdata, ext_last_wdata);
      end
    end

    // Both ports hit L2 in the same cycle, winner must alternate
    prev_win = 1'b0;
    for (int r = 0; r < NumRounds; r++) begin
      if (r % 2 == 0) begin
        wd0 = $urandom;
        wd1 = $urandom;
        fork
          run_txn(0, 1'b1, L2Base + addr_t'((500 + r) * 4), wd0, 4'hF, rd0, gc0);
          run_txn(1, 1'b1, L2Base + addr_t'((600 + r) * 4), wd1, 4'hF, rd1, gc1);
        join
        l2_ref[500 + r] = wd0;
        l2_ref[600 + r] = wd1;
      end else begin
        fork
          run_txn(0, 1'b0, L2Base + addr_t'((599 + r) * 4), '0, 4'hF, rd0, gc0);
          run_txn(1, 1'b0, L2Base + addr_t'((499 + r) * 4), '0, 4'hF, rd1, gc1);
        join
        check_data($sformatf("contention %0d cluster", r), l2_ref[599 + r], rd0);
        check_data($sformatf("contention %0d host", r), l2_ref[499 + r], rd1);
      end
      win = (gc1 < gc0);
      if (r > 0) check_bit($sformatf("contention %0d winner", r), ~prev_win, win);
      prev_win = win;
    end

    // Two transactions in flight on the external port
    fork
      run_txn(0, 1'b0, 32'h3000_0100, '0, 4'hF, rd0, gc0);
      run_txn(1, 1'b0, 32'h3000_0200, '0, 4'hF, rd1, gc1);
    join
    check_data("ext shared cluster", 32'h3000_0100 ^ ExtXorKey, rd0);
    check_data("ext shared host", 32'h3000_0200 ^ ExtXorKey, rd1);

    repeat (2) @(negedge clk_i);
    for (int p = 0; p < 2; p++) begin
      check_data($sformatf("port %0d rvalid count", p), data_t'(gnt_cnt[p]),
                 data_t'(rv_cnt[p]));
    end

    report_counts();
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* source/mem_system.sv */
////////////////////////////////////////////////////////////
// Memory system top: cluster and host ports into the
// crossbar, with registers, L2, ROM and an external port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_system (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Cluster port
  input  logic                         clu_req_i,
  input  logic                         clu_we_i,
  input  sys_pkg::addr_t               clu_addr_i,
  input  sys_pkg::data_t               clu_wdata_i,
  input  sys_pkg::strb_t               clu_be_i,
  output logic                         clu_gnt_o,
  output logic                         clu_rvalid_o,
  output sys_pkg::data_t               clu_rdata_o,
  // Host port
  input  logic                         host_req_i,
  input  logic                         host_we_i,
  input  sys_pkg::addr_t               host_addr_i,
  input  sys_pkg::data_t               host_wdata_i,
  input  sys_pkg::strb_t               host_be_i,
  output logic                         host_gnt_o,
  output logic                         host_rvalid_o,
  output sys_pkg::data_t               host_rdata_o,
  // External target
  output logic                         ext_req_o,
  output logic                         ext_we_o,
  output sys_pkg::addr_t               ext_addr_o,
  output sys_pkg::data_t               ext_wdata_o,
  output sys_pkg::strb_t               ext_be_o,
  input  logic                         ext_gnt_i,
  input  logic                         ext_rvalid_i,
  input  sys_pkg::data_t               ext_rdata_i,
  output logic [sys_pkg::NumCores-1:0] wake_up_o,
  output logic                         eoc_valid_o
);
  import sys_pkg::*;

  mem_bus_if init_bus [NumInits] ();
  mem_bus_if tgt_bus [NumTargets] ();

  // Cluster on initiator 0
  assign init_bus[0].req   = clu_req_i;
  assign init_bus[0].we    = clu_we_i;
  assign init_bus[0].addr  = clu_addr_i;
  assign init_bus[0].wdata = clu_wdata_i;
  assign init_bus[0].be    = clu_be_i;
  assign clu_gnt_o         = init_bus[0].gnt;
  assign clu_rvalid_o      = init_bus[0].rvalid;
  assign clu_rdata_o       = init_bus[0].rdata;

  // Host on initiator 1
  assign init_bus[1].req   = host_req_i;
  assign init_bus[1].we    = host_we_i;
  assign init_bus[1].addr  = host_addr_i;
  assign init_bus[1].wdata = host_wdata_i;
  assign init_bus[1].be    = host_be_i;
  assign host_gnt_o        = init_bus[1].gnt;
  assign host_rvalid_o     = init_bus[1].rvalid;
  assign host_rdata_o      = init_bus[1].rdata;

  sys_xbar u_xbar (
    .clk_i   (clk_i   ),
    .rst_i   (rst_i   ),
    .init_bus(init_bus),
    .tgt_bus (tgt_bus )
  );

  ctrl_regs u_ctrl_regs (
    .clk_i      (clk_i            ),
    .rst_i      (rst_i            ),
    .bus        (tgt_bus[CtrlRegs]),
    .wake_up_o  (wake_up_o        ),
    .eoc_valid_o(eoc_valid_o      )
  );

  l2_sram u_l2_sram (
    .clk_i(clk_i         ),
    .rst_i(rst_i         ),
    .bus  (tgt_bus[L2Mem])
  );

  bootrom u_bootrom (
    .clk_i(clk_i           ),
    .rst_i(rst_i           ),
    .bus  (tgt_bus[BootRom])
  );

  // External target leaves the fabric as plain ports
  assign ext_req_o               = tgt_bus[External].req;
  assign ext_we_o                = tgt_bus[External].we;
  assign ext_addr_o              = tgt_bus[External].addr;
  assign ext_wdata_o             = tgt_bus[External].wdata;
  assign ext_be_o                = tgt_bus[External].be;
  assign tgt_bus[External].gnt    = ext_gnt_i;
  assign tgt_bus[External].rvalid = ext_rvalid_i;
  assign tgt_bus[External].rdata  = ext_rdata_i;

endmodule

/* source/ctrl_regs.sv */
////////////////////////////////////////////////////////////
// System control registers: end of computation, core
// wake-up pulses and read-only system information
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ctrl_regs (
  input  logic                         clk_i,
  input  logic                         rst_i,
  mem_bus_if.tgt                       bus,
  output logic [sys_pkg::NumCores-1:0] wake_up_o,
  output logic                         eoc_valid_o
);
  import sys_pkg::*;

  addr_t               reg_off;
  logic                wr_en;
  logic                rd_en;
  data_t               rd_word;
  data_t               rdata_q;
  logic                rvalid_q;
  eoc_u                eoc_q;
  logic [NumCores-1:0] wake_q;

  assign reg_off = bus.addr - CtrlBase;
  assign bus.gnt = bus.req;
  assign wr_en   = bus.req && bus.gnt && bus.we;
  assign rd_en   = bus.req && bus.gnt && !bus.we;

  // Read mux
  always_comb begin
    case (reg_off)
      EocOffset:       rd_word = eoc_q.raw;
      TcdmStartOffset: rd_word = TcdmBase;
      TcdmEndOffset:   rd_word = TcdmBase + TcdmSize - 1;
      NumCoresOffset:  rd_word = data_t'(NumCores);
      default:         rd_word = '0;  // Wake-up reads as zero too
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q    <= '0;
      wake_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
      wake_q   <= '0;
      if (wr_en && reg_off == WakeOffset) begin
        wake_q <= bus.wdata[NumCores-1:0];  // Single-cycle pulse
      end
      if (wr_en && reg_off == EocOffset) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (bus.be[b]) eoc_q.raw[8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) rdata_q <= rd_word;
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign wake_up_o   = wake_q;
  assign eoc_valid_o = eoc_q.fields.done;  // Level, follows the stored flag

  // Wake-up is a pulse, never a level
  assert property (@(posedge clk_i) disable iff (rst_i)
    |wake_up_o |=> !(|wake_up_o));

endmodule

/* source/bootrom.sv */
////////////////////////////////////////////////////////////
// Boot image ROM with registered read data. Writes are
// acknowledged but leave the image unchanged
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bootrom (
  input logic    clk_i,
  input logic    rst_i,
  mem_bus_if.tgt bus
);
  import sys_pkg::*;

  addr_t word_off;
  data_t rom_word;
  data_t rdata_q;
  logic  rvalid_q;

  assign word_off = (bus.addr - RomBase) >> ByteOffset;
  assign bus.gnt  = bus.req;

  // Zero past the end of the image
  always_comb begin
    rom_word = '0;
    if (word_off < BootWords) rom_word = BootImage[word_off];
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt && !bus.we) rdata_q <= rom_word;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;  // Writes still get a response
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

/* source/l2_sram.sv */
////////////////////////////////////////////////////////////
// L2 scratch memory, single port with byte enables.
// Always grants and answers one cycle after the grant
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module l2_sram (
  input logic    clk_i,
  input logic    rst_i,
  mem_bus_if.tgt bus
);
  import sys_pkg::*;

  data_t                  mem_q [L2NumWords];
  logic [L2AddrWidth-1:0] word_idx;
  data_t                  rdata_q;
  logic                   rvalid_q;

  assign word_idx = bus.addr[ByteOffset +: L2AddrWidth];  // Base is size aligned
  assign bus.gnt  = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt) begin
      if (bus.we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (bus.be[b]) mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    bus.req |-> !$isunknown(bus.addr));

endmodule

/* source/sys_xbar.sv */
////////////////////////////////////////////////////////////
// Two-initiator to four-target crossbar with address decode,
// per-target round-robin and in-order response steering
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sys_xbar (
  input logic    clk_i,
  input logic    rst_i,
  mem_bus_if.tgt  init_bus [sys_pkg::NumInits],
  mem_bus_if.init tgt_bus  [sys_pkg::NumTargets]
);
  import sys_pkg::*;

  // Initiator side, flattened
  logic    in_req   [NumInits];
  addr_t   in_addr  [NumInits];
  logic    in_we    [NumInits];
  data_t   in_wdata [NumInits];
  strb_t   in_be    [NumInits];
  target_e in_sel   [NumInits];
  logic    in_gnt   [NumInits];

  logic [NumInits-1:0] pend_q;     // Response outstanding per initiator
  logic [NumInits-1:0] rsp_valid;
  data_t               rsp_rdata [NumInits];

  // Target side
  logic [NumInits-1:0]   cand [NumTargets];
  logic [NumTargets-1:0] win;         // Selected initiator per target
  logic [NumTargets-1:0] last_q;      // Last winner under contention
  logic [NumTargets-1:0] hold_q;      // Request waiting on gnt
  logic [NumTargets-1:0] hold_win_q;
  logic [NumTargets-1:0] tgt_req;
  logic [NumTargets-1:0] tgt_gnt;
  logic [NumTargets-1:0] tgt_rvalid;
  data_t                 tgt_rdata [NumTargets];

  // In-order queue of granted initiator indices, two deep
  logic [1:0]            order_q [NumTargets];
  logic [NumTargets-1:0] wr_ptr_q;
  logic [NumTargets-1:0] rd_ptr_q;

  for (genvar i = 0; i < NumInits; i++) begin : g_init
    assign in_req[i]   = init_bus[i].req;
    assign in_addr[i]  = init_bus[i].addr;
    assign in_we[i]    = init_bus[i].we;
    assign in_wdata[i] = init_bus[i].wdata;
    assign in_be[i]    = init_bus[i].be;
    assign in_sel[i]   = decode_addr(init_bus[i].addr);

    // Granted only when this initiator wins its target and the target accepts
    assign in_gnt[i] = cand[in_sel[i]][i] && (win[in_sel[i]] == 1'(i)) && tgt_gnt[in_sel[i]];

    assign init_bus[i].gnt    = in_gnt[i];
    assign init_bus[i].rvalid = rsp_valid[i];
    assign init_bus[i].rdata  = rsp_rdata[i];

    assert property (@(posedge clk_i) disable iff (rst_i)
      init_bus[i].gnt |-> init_bus[i].req);
    assert property (@(posedge clk_i) disable iff (rst_i)
      init_bus[i].rvalid |-> pend_q[i]);
  end

  for (genvar t = 0; t < NumTargets; t++) begin : g_tgt
    assign tgt_req[t]       = |cand[t];
    assign tgt_bus[t].req   = tgt_req[t];
    assign tgt_bus[t].addr  = in_addr[win[t]];
    assign tgt_bus[t].we    = in_we[win[t]];
    assign tgt_bus[t].wdata = in_wdata[win[t]];
    assign tgt_bus[t].be    = in_be[win[t]];

    assign tgt_gnt[t]    = tgt_bus[t].gnt;
    assign tgt_rvalid[t] = tgt_bus[t].rvalid;
    assign tgt_rdata[t]  = tgt_bus[t].rdata;
  end

  // Candidate requests and round-robin pick
  always_comb begin
    for (int t = 0; t < NumTargets; t++) begin
      for (int i = 0; i < NumInits; i++) begin
        cand[t][i] = in_req[i] && !pend_q[i] && (in_sel[i] == target_e'(t));
      end
      if (hold_q[t]) begin
        win[t] = hold_win_q[t];  // Keep the stalled request stable
      end else if (&cand[t]) begin
        win[t] = ~last_q[t];
      end else begin
        win[t] = cand[t][1];
      end
    end
  end

  // Steer each response to the oldest granted initiator
  always_comb begin
    for (int i = 0; i < NumInits; i++) begin
      rsp_valid[i] = 1'b0;
      rsp_rdata[i] = '0;
      for (int t = 0; t < NumTargets; t++) begin
        if (tgt_rvalid[t] && order_q[t][rd_ptr_q[t]] == 1'(i)) begin
          rsp_valid[i] = 1'b1;
          rsp_rdata[i] = tgt_rdata[t];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q     <= '0;
      last_q     <= '0;
      hold_q     <= '0;
      hold_win_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      for (int i = 0; i < NumInits; i++) begin
        pend_q[i] <= (pend_q[i] && !rsp_valid[i]) || in_gnt[i];
      end
      for (int t = 0; t < NumTargets; t++) begin
        hold_q[t]     <= tgt_req[t] && !tgt_gnt[t];
        hold_win_q[t] <= win[t];
        if (tgt_req[t] && tgt_gnt[t]) begin
          wr_ptr_q[t] <= ~wr_ptr_q[t];
          if (&cand[t]) last_q[t] <= win[t];  // Only contention moves the pointer
        end
        if (tgt_rvalid[t]) rd_ptr_q[t] <= ~rd_ptr_q[t];
      end
    end
  end

  // Queue storage
  always_ff @(posedge clk_i) begin
    for (int t = 0; t < NumTargets; t++) begin
      if (tgt_req[t] && tgt_gnt[t]) order_q[t][wr_ptr_q[t]] <= win[t];
    end
  end

endmodule

/* source/mem_bus_if.sv */
////////////////////////////////////////////////////////////
// One request/response memory link. Initiators take the
// init modport, targets the tgt modport
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface mem_bus_if;
  import sys_pkg::*;

  // Request side
  logic  req;
  addr_t addr;
  logic  we;
  data_t wdata;
  strb_t be;

  // Response side
  logic  gnt;
  logic  rvalid;  // One pulse per granted transaction, in order
  data_t rdata;   // Valid on reads only

  modport init (
    output req, addr, we, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport tgt (
    input  req, addr, we, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface

/* source/sys_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types, address map and constants of the memory
// fabric. Import into any block that needs the map
////////////////////////////////////////////////////////////

package sys_pkg;

  localparam int AddrWidth  = 32;
  localparam int DataWidth  = 32;
  localparam int StrbWidth  = DataWidth / 8;
  localparam int ByteOffset = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  localparam int NumCores    = 8;
  localparam int L2NumWords  = 1024;
  localparam int L2AddrWidth = $clog2(L2NumWords);
  localparam int L2Size      = L2NumWords * StrbWidth;  // In bytes

  // System address map
  localparam addr_t CtrlBase = 32'h4000_0000;
  localparam addr_t CtrlEnd  = 32'h4000_FFFF;
  localparam addr_t L2Base   = 32'h8000_0000;
  localparam addr_t L2End    = L2Base + L2Size - 1;
  localparam addr_t RomBase  = 32'hA000_0000;
  localparam addr_t RomEnd   = 32'hA000_FFFF;

  // Reported through the read-only info registers
  localparam addr_t TcdmBase = 32'h0000_0000;
  localparam addr_t TcdmSize = 32'h0010_0000;

  // Control register offsets
  localparam addr_t EocOffset       = 32'h00;
  localparam addr_t WakeOffset      = 32'h04;
  localparam addr_t TcdmStartOffset = 32'h08;
  localparam addr_t TcdmEndOffset   = 32'h0C;
  localparam addr_t NumCoresOffset  = 32'h10;

  typedef enum logic [1:0] {
    CtrlRegs,
    L2Mem,
    BootRom,
    External
  } target_e;

  localparam int NumTargets = 4;
  localparam int NumInits   = 2;

  localparam int BootWords = 16;
  localparam data_t BootImage [BootWords] = '{
    32'h0000_0297, 32'h0202_8293, 32'h3052_9073, 32'hF140_2573,
    32'h0000_0597, 32'h0405_8593, 32'h4000_0637, 32'h00A6_2023,
    32'h1050_0073, 32'hFFDF_F06F, 32'h0000_0013, 32'h0000_0013,
    32'hDEAD_BEEF, 32'hCAFE_F00D, 32'h1234_5678, 32'h8765_4321
  };

  // End-of-computation word, exit code above the done flag
  typedef struct packed {
    logic [DataWidth-2:0] code;
    logic                 done;
  } eoc_t;

  typedef union packed {
    data_t raw;
    eoc_t  fields;
  } eoc_u;

  // Anything outside the map goes to the external port
  function automatic target_e decode_addr(addr_t addr);
    if (addr >= CtrlBase && addr <= CtrlEnd) return CtrlRegs;
    if (addr >= L2Base && addr <= L2End) return L2Mem;
    if (addr >= RomBase && addr <= RomEnd) return BootRom;
    return External;
  endfunction

endpackage
